/* verilog/csr_pkg.sv */
// machine-mode CSR definitions only; privilege levels and traps are not modeled here
package csr_pkg;

  // data and field types
  typedef logic [31:0] word;
  typedef logic [4:0]  reg_idx_t;
  typedef logic [11:0] csr_addr_t;

  // funct3 of a SYSTEM instruction
  // 0 and 4 are not CSR operations and decode as CSR_NONE
  typedef enum logic [2:0] {
    CSR_NONE = 3'd0,
    CSRRW    = 3'd1,
    CSRRS    = 3'd2,
    CSRRC    = 3'd3,
    CSRRWI   = 3'd5,
    CSRRSI   = 3'd6,
    CSRRCI   = 3'd7
  } csr_op_t;

  // major opcode shared by ecall/ebreak and the CSR group
  localparam logic [6:0] OPCODE_SYSTEM = 7'h73;

  // implemented CSR addresses
  localparam csr_addr_t ADDR_MSCRATCH  = 12'h340;
  localparam csr_addr_t ADDR_MTVEC     = 12'h305;
  // custom read/write space
  localparam csr_addr_t ADDR_MCUSTOM   = 12'h7C0;
  localparam csr_addr_t ADDR_MCYCLE    = 12'hB00;
  localparam csr_addr_t ADDR_MVENDORID = 12'hF11;

  // defaults for the top-level parameters
  localparam word         DEFAULT_MTVEC_RESET  = 32'h0000_0100;
  localparam word         DEFAULT_VENDOR_ID    = 32'h0000_0A5C;
  localparam int unsigned DEFAULT_CUSTOM_WIDTH = 5;

  // true for the six funct3 codes that are CSR operations
  function automatic logic is_csr_op(logic [2:0] funct3);
    logic result;
    case (funct3)
      3'd1, 3'd2, 3'd3, 3'd5, 3'd6, 3'd7: result = 1'b1;
      default: result = 1'b0;
    endcase
    return result;
  endfunction

  // an access writes unless it is set/clear with x0 or a zero immediate
  function automatic logic is_write_access(csr_op_t op, reg_idx_t rs1_zimm);
    logic result;
    case (op)
      CSRRW, CSRRWI: result = 1'b1;
      CSRRS, CSRRC, CSRRSI, CSRRCI: result = (rs1_zimm != '0);
      default: result = 1'b0;
    endcase
    return result;
  endfunction

endpackage

/* verilog/csr_reg.sv */
// one CSR; CsrWidth of at least 5 keeps zimm intact, wider than 32 is cut on out
module csr_reg import csr_pkg::*; #(
  parameter int unsigned           CsrWidth   = 32,
  parameter logic [CsrWidth-1:0]   ResetValue = '0,
  parameter csr_addr_t             Addr       = '0,
  parameter bit                    Write      = 1'b1
) (
  input  logic                clk,
  input  logic                reset,
  input  logic                csr_enable,
  input  csr_addr_t           csr_addr,
  input  csr_op_t             csr_op,
  input  reg_idx_t            rs1_zimm,
  input  word                 rs1_data,
  // side-effect path, wins over instructions
  input  logic [CsrWidth-1:0] ext_data,
  input  logic                ext_write_enable,
  output word                 out,
  output logic                selected,
  output logic                denied
);

  typedef logic [CsrWidth-1:0] csr_data_t;

  csr_data_t data;
  csr_data_t next_data;
  csr_data_t reg_operand;
  csr_data_t imm_operand;
  logic      writing;

  assign selected    = (csr_addr == Addr);
  assign writing     = is_write_access(csr_op, rs1_zimm);
  assign reg_operand = csr_data_t'(rs1_data);
  // zimm is zero-extended
  assign imm_operand = csr_data_t'(rs1_zimm);

  // read-only register hit by a writing op
  assign denied = csr_enable && selected && !Write && writing;

  always_comb begin
    next_data = data;
    if (csr_enable && selected && Write) begin
      case (csr_op)
        CSRRW:  next_data = reg_operand;
        CSRRWI: next_data = imm_operand;
        // set/clear with x0 or zimm 0 is a pure read
        CSRRS:  if (rs1_zimm != '0) next_data = data | reg_operand;
        CSRRC:  if (rs1_zimm != '0) next_data = data & ~reg_operand;
        CSRRSI: if (rs1_zimm != '0) next_data = data | imm_operand;
        CSRRCI: if (rs1_zimm != '0) next_data = data & ~imm_operand;
        default: next_data = data;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      data <= ResetValue;
    end else if (ext_write_enable) begin
      data <= ext_data;
    end else begin
      data <= next_data;
    end
  end

  // old value, before this cycle's update
  assign out = word'(data);

endmodule

/* verilog/csr_decode.sv */
// accepts one word per cycle with no back-pressure; only SYSTEM words with a CSR funct3 issue
module csr_decode import csr_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  logic      instr_valid,
  input  word       instr,
  input  word       rs1_data,
  output logic      req_valid,
  output csr_addr_t req_addr,
  output csr_op_t   req_op,
  output reg_idx_t  req_zimm,
  output reg_idx_t  req_rd,
  output word       req_rs1_data
);

  // instruction fields, I-type layout
  logic [6:0] opcode;
  logic [2:0] funct3;
  csr_addr_t  addr_field;
  reg_idx_t   rs1_field;
  reg_idx_t   rd_field;
  logic       accept;

  assign opcode     = instr[6:0];
  assign rd_field   = instr[11:7];
  assign funct3     = instr[14:12];
  // same bits serve as rs1 index and as zimm
  assign rs1_field  = instr[19:15];
  assign addr_field = instr[31:20];

  // ecall/ebreak (funct3 0) and funct3 4 fall out here
  assign accept = instr_valid && (opcode == OPCODE_SYSTEM) && is_csr_op(funct3);

  // request strobe, one cycle per accepted instruction
  always_ff @(posedge clk) begin
    if (reset) begin
      req_valid <= 1'b0;
    end else begin
      req_valid <= accept;
    end
  end

  // payload only moves on an accepted word
  always_ff @(posedge clk) begin
    if (accept) begin
      req_addr     <= addr_field;
      req_op       <= csr_op_t'(funct3);
      req_zimm     <= rs1_field;
      req_rd       <= rd_field;
      req_rs1_data <= rs1_data;
    end
  end

endmodule

/* verilog/csr_file.sv */
// five fixed CSRs; mcycle wraps at 32 bits and counts every cycle out of reset
module csr_file import csr_pkg::*; #(
  parameter word         MtvecReset  = DEFAULT_MTVEC_RESET,
  parameter word         VendorId    = DEFAULT_VENDOR_ID,
  parameter int unsigned CustomWidth = DEFAULT_CUSTOM_WIDTH
) (
  input  logic      clk,
  input  logic      reset,
  input  logic      req_valid,
  input  csr_addr_t req_addr,
  input  csr_op_t   req_op,
  input  reg_idx_t  req_zimm,
  input  word       req_rs1_data,
  output word       rd_value,
  output logic      access_illegal
);

  localparam int NumCsrs = 5;

  // bank slots
  localparam int IdxMscratch  = 0;
  localparam int IdxMtvec     = 1;
  localparam int IdxMcustom   = 2;
  localparam int IdxMcycle    = 3;
  localparam int IdxMvendorid = 4;

  word                reg_out [NumCsrs];
  logic [NumCsrs-1:0] hit;
  logic [NumCsrs-1:0] deny;
  word                mcycle_next;

  csr_reg #(
    .CsrWidth(32), .ResetValue('0), .Addr(ADDR_MSCRATCH), .Write(1'b1)
  ) mscratch_i (
    .clk, .reset, .csr_enable(req_valid), .csr_addr(req_addr), .csr_op(req_op),
    .rs1_zimm(req_zimm), .rs1_data(req_rs1_data),
    .ext_data(32'd0), .ext_write_enable(1'b0),
    .out(reg_out[IdxMscratch]), .selected(hit[IdxMscratch]), .denied(deny[IdxMscratch])
  );

  csr_reg #(
    .CsrWidth(32), .ResetValue(MtvecReset), .Addr(ADDR_MTVEC), .Write(1'b1)
  ) mtvec_i (
    .clk, .reset, .csr_enable(req_valid), .csr_addr(req_addr), .csr_op(req_op),
    .rs1_zimm(req_zimm), .rs1_data(req_rs1_data),
    .ext_data(32'd0), .ext_write_enable(1'b0),
    .out(reg_out[IdxMtvec]), .selected(hit[IdxMtvec]), .denied(deny[IdxMtvec])
  );

  csr_reg #(
    .CsrWidth(CustomWidth), .ResetValue('0), .Addr(ADDR_MCUSTOM), .Write(1'b1)
  ) mcustom_i (
    .clk, .reset, .csr_enable(req_valid), .csr_addr(req_addr), .csr_op(req_op),
    .rs1_zimm(req_zimm), .rs1_data(req_rs1_data),
    .ext_data('0), .ext_write_enable(1'b0),
    .out(reg_out[IdxMcustom]), .selected(hit[IdxMcustom]), .denied(deny[IdxMcustom])
  );

  // counter rides the external write path every cycle
  assign mcycle_next = reg_out[IdxMcycle] + 32'd1;

  csr_reg #(
    .CsrWidth(32), .ResetValue('0), .Addr(ADDR_MCYCLE), .Write(1'b0)
  ) mcycle_i (
    .clk, .reset, .csr_enable(req_valid), .csr_addr(req_addr), .csr_op(req_op),
    .rs1_zimm(req_zimm), .rs1_data(req_rs1_data),
    .ext_data(mcycle_next), .ext_write_enable(1'b1),
    .out(reg_out[IdxMcycle]), .selected(hit[IdxMcycle]), .denied(deny[IdxMcycle])
  );

  // constant, held by reset value alone
  csr_reg #(
    .CsrWidth(32), .ResetValue(VendorId), .Addr(ADDR_MVENDORID), .Write(1'b0)
  ) mvendorid_i (
    .clk, .reset, .csr_enable(req_valid), .csr_addr(req_addr), .csr_op(req_op),
    .rs1_zimm(req_zimm), .rs1_data(req_rs1_data),
    .ext_data(VendorId), .ext_write_enable(1'b0),
    .out(reg_out[IdxMvendorid]), .selected(hit[IdxMvendorid]), .denied(deny[IdxMvendorid])
  );

  // addresses are distinct, so at most one hit
  always_comb begin
    rd_value = '0;
    for (int i = 0; i < NumCsrs; i++) begin
      if (hit[i]) begin
        rd_value = rd_value | reg_out[i];
      end
    end
  end

  // unimplemented address or write to a read-only CSR
  assign access_illegal = req_valid && ((hit == '0) || (deny != '0));

endmodule

/* verilog/csr_writeback.sv */
// result stage, no stall; writes to x0 are dropped silently and never flagged
module csr_writeback import csr_pkg::*; (
  input  logic     clk,
  input  logic     reset,
  input  logic     req_valid,
  input  reg_idx_t req_rd,
  input  word      rd_value,
  input  logic     access_illegal,
  output logic     rd_valid,
  output reg_idx_t rd_addr,
  output word      rd_data,
  output logic     illegal
);

  logic legal;
  logic deliver;

  assign legal   = req_valid && !access_illegal;
  // x0 destination updates the CSR but returns nothing
  assign deliver = legal && (req_rd != '0);

  // result strobes, one cycle each
  always_ff @(posedge clk) begin
    if (reset) begin
      rd_valid <= 1'b0;
      illegal  <= 1'b0;
    end else begin
      rd_valid <= deliver;
      illegal  <= req_valid && access_illegal;
    end
  end

  // hold last delivered result
  always_ff @(posedge clk) begin
    if (deliver) begin
      rd_addr <= req_rd;
      rd_data <= rd_value;
    end
  end

endmodule

/* verilog/csr_unit.sv */
// two-cycle CSR pipeline with no hazards or back-pressure; rd_data valid only with rd_valid
module csr_unit import csr_pkg::*; #(
  parameter word         MtvecReset  = DEFAULT_MTVEC_RESET,
  parameter word         VendorId    = DEFAULT_VENDOR_ID,
  parameter int unsigned CustomWidth = DEFAULT_CUSTOM_WIDTH
) (
  input  logic     clk,
  input  logic     reset,
  input  logic     instr_valid,
  input  word      instr,
  input  word      rs1_data,
  output logic     rd_valid,
  output reg_idx_t rd_addr,
  output word      rd_data,
  output logic     illegal
);

  // stage one request
  logic      req_valid;
  csr_addr_t req_addr;
  csr_op_t   req_op;
  reg_idx_t  req_zimm;
  reg_idx_t  req_rd;
  word       req_rs1_data;

  // bank response
  word       rd_value;
  logic      access_illegal;

  csr_decode csr_decode_i (
    .clk,
    .reset,
    .instr_valid,
    .instr,
    .rs1_data,
    .req_valid,
    .req_addr,
    .req_op,
    .req_zimm,
    .req_rd,
    .req_rs1_data
  );

  csr_file #(
    .MtvecReset(MtvecReset),
    .VendorId(VendorId),
    .CustomWidth(CustomWidth)
  ) csr_file_i (
    .clk,
    .reset,
    .req_valid,
    .req_addr,
    .req_op,
    .req_zimm,
    .req_rs1_data,
    .rd_value,
    .access_illegal
  );

  csr_writeback csr_writeback_i (
    .clk,
    .reset,
    .req_valid,
    .req_rd,
    .rd_value,
    .access_illegal,
    .rd_valid,
    .rd_addr,
    .rd_data,
    .illegal
  );

endmodule

/* verification/csr_unit_checker.sv */
// port-level assertions for csr_unit; assumes the fixed two-cycle latency and no stall
module csr_unit_checker import csr_pkg::*; (
  input logic     clk,
  input logic     reset,
  input logic     instr_valid,
  input word      instr,
  input logic     rd_valid,
  input reg_idx_t rd_addr,
  input logic     illegal
);

  logic csr_word;
  logic has_rd;

  // funct3 0 and 4 both have zero in the low two bits
  assign csr_word = instr_valid && (instr[6:0] == OPCODE_SYSTEM) && (instr[13:12] != 2'b00);
  assign has_rd   = (instr[11:7] != 5'd0);

  strobes_exclusive: assert property (@(posedge clk) disable iff (reset)
    !(rd_valid && illegal)) else $error("rd_valid and illegal high in the same cycle");

  rd_nonzero: assert property (@(posedge clk) disable iff (reset)
    rd_valid |-> (rd_addr != 5'd0)) else $error("rd_valid with destination x0");

  quiet_after_reset: assert property (@(posedge clk)
    reset |=> (!rd_valid && !illegal)) else $error("result strobe right after reset");

  result_with_rd: assert property (@(posedge clk) disable iff (reset)
    (csr_word && has_rd) |-> ##2 (rd_valid || illegal)) else $error("CSR result missing");

  // x0 destination gives no rd_valid
  result_without_rd: assert property (@(posedge clk) disable iff (reset)
    (csr_word && !has_rd) |-> ##2 !rd_valid) else $error("rd_valid for x0 destination");

endmodule

/* verification/csr_unit_tb.sv */
// default parameters only; expected results come from a bank model, one result per issue
module csr_unit_tb import csr_pkg::*; ();

  localparam word MtvecReset  = 32'h0000_0100;
  localparam word VendorId    = 32'h0000_0A5C;
  localparam int  CustomWidth = 5;
  localparam word CustomMask  = (32'd1 << CustomWidth) - 32'd1;

  typedef struct packed {
    int       due;
    logic     valid;
    logic     illegal;
    reg_idx_t rd;
    word      data;
  } expect_t;

  logic     clk;
  logic     reset;
  logic     instr_valid;
  word      instr;
  word      rs1_data;
  logic     rd_valid;
  reg_idx_t rd_addr;
  word      rd_data;
  logic     illegal;

  // model of the writable registers
  word      m_scratch;
  word      m_tvec;
  word      m_custom;
  word      seed;
  int       cycles;
  int       errors;
  int       checks;
  int       tests;
  int       timeouts;
  expect_t  exp_q[$];

  csr_unit #(.MtvecReset(MtvecReset), .VendorId(VendorId), .CustomWidth(CustomWidth)) csr_unit_i (
    .clk, .reset, .instr_valid, .instr, .rs1_data, .rd_valid, .rd_addr, .rd_data, .illegal
  );

  bind csr_unit csr_unit_checker csr_unit_checker_i (
    .clk, .reset, .instr_valid, .instr, .rd_valid, .rd_addr, .illegal
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  // rising edges since reset release
  always @(posedge clk) begin
    if (reset) begin
      cycles <= 0;
    end else begin
      cycles <= cycles + 1;
    end
  end

  function automatic word lcg_next();
    seed = seed * 32'd1103515245 + 32'd12345;
    return seed;
  endfunction

  // expected result of one CSR instruction, updates the model
  function automatic expect_t predict(logic [2:0] funct3, csr_addr_t addr, reg_idx_t zimm,
                                      word rs1v, reg_idx_t rd);
    expect_t e;
    word     old;
    word     operand;
    word     result;
    logic    known;
    logic    read_only;
    logic    writing;
    known     = 1'b1;
    read_only = 1'b0;
    case (addr)
      ADDR_MSCRATCH: old = m_scratch;
      ADDR_MTVEC:    old = m_tvec;
      ADDR_MCUSTOM:  old = m_custom;
      ADDR_MCYCLE: begin
        old       = word'(cycles + 1);
        read_only = 1'b1;
      end
      ADDR_MVENDORID: begin
        old       = VendorId;
        read_only = 1'b1;
      end
      default: begin
        old   = '0;
        known = 1'b0;
      end
    endcase
    // funct3 bit 2 picks the immediate form
    operand = funct3[2] ? word'(zimm) : rs1v;
    writing = (funct3[1:0] == 2'b01) || (zimm != '0);
    case (funct3[1:0])
      2'b01:   result = operand;
      2'b10:   result = old | operand;
      default: result = old & ~operand;
    endcase
    e.due     = cycles + 2;
    e.illegal = !known || (read_only && writing);
    e.valid   = !e.illegal && (rd != '0);
    e.rd      = rd;
    e.data    = old;
    if (!e.illegal && writing) begin
      case (addr)
        ADDR_MSCRATCH: m_scratch = result;
        ADDR_MTVEC:    m_tvec = result;
        ADDR_MCUSTOM:  m_custom = result & CustomMask;
        default: begin
        end
      endcase
    end
    return e;
  endfunction

  task automatic send_csr(logic [2:0] funct3, csr_addr_t addr, reg_idx_t zimm, word rs1v,
                          reg_idx_t rd);
    instr_valid = 1'b1;
    instr       = {addr, zimm, funct3, rd, OPCODE_SYSTEM};
    rs1_data    = rs1v;
    exp_q.push_back(predict(funct3, addr, zimm, rs1v, rd));
    @(negedge clk);
    instr_valid = 1'b0;
  endtask

  // a word the unit must ignore
  task automatic drive_word(word w);
    instr_valid = 1'b1;
    instr       = w;
    rs1_data    = lcg_next();
    @(negedge clk);
    instr_valid = 1'b0;
  endtask

  task automatic report_mismatch(string what, word got, word want);
    $display("FAILED %0t: %s got %h expected %h", $time, what, got, want);
    errors++;
  endtask

  task automatic finish_test(string name, int base);
    int t;
    t = 0;
    while (exp_q.size() > 0 && t < 50) begin
      @(negedge clk);
      t++;
    end
    if (exp_q.size() > 0) begin
      $display("timeout: %0d results never arrived in %s", exp_q.size(), name);
      timeouts++;
      exp_q.delete();
    end
    tests++;
    $display("test %0d %s: %0d errors", tests, name, errors - base);
  endtask

  // compares each due result on the falling edge
  always @(negedge clk) begin : compare
    expect_t e;
    if (!reset) begin
      if (exp_q.size() > 0 && exp_q[0].due == cycles) begin
        e = exp_q.pop_front();
        checks++;
        if (rd_valid !== e.valid || illegal !== e.illegal) begin
          report_mismatch("strobes {rd_valid,illegal}", {30'd0, rd_valid, illegal},
                          {30'd0, e.valid, e.illegal});
        end else if (e.valid && rd_addr !== e.rd) begin
          report_mismatch("rd_addr", word'(rd_addr), word'(e.rd));
        end else if (e.valid && rd_data !== e.data) begin
          report_mismatch("rd_data", rd_data, e.data);
        end
      end else if (rd_valid || illegal) begin
        $display("error: result strobe at %0t with no instruction due", $time);
        errors++;
      end
    end
  end

  initial begin
    int         base;
    int         k;
    word        r;
    word        w;
    word        d;
    csr_addr_t  addr;
    logic [2:0] f3;
    seed        = 32'd22607;
    m_scratch   = '0;
    m_tvec      = MtvecReset;
    m_custom    = '0;
    errors      = 0;
    checks      = 0;
    tests       = 0;
    timeouts    = 0;
    reset       = 1'b1;
    instr_valid = 1'b0;
    instr       = '0;
    rs1_data    = '0;
    repeat (3) @(negedge clk);
    reset = 1'b0;

    base = errors;
    send_csr(CSRRS, ADDR_MSCRATCH, 5'd0, '0, 5'd1);
    send_csr(CSRRS, ADDR_MTVEC, 5'd0, '0, 5'd2);
    send_csr(CSRRS, ADDR_MCUSTOM, 5'd0, '0, 5'd3);
    send_csr(CSRRSI, ADDR_MVENDORID, 5'd0, '0, 5'd4);
    send_csr(CSRRW, ADDR_MSCRATCH, 5'd7, 32'hDEAD_BEEF, 5'd5);
    send_csr(CSRRWI, ADDR_MTVEC, 5'd9, 32'hFFFF_FFFF, 5'd6);
    send_csr(CSRRW, ADDR_MTVEC, 5'd3, 32'h8000_0004, 5'd7);
    send_csr(CSRRWI, ADDR_MSCRATCH, 5'd21, '0, 5'd8);
    send_csr(CSRRS, ADDR_MSCRATCH, 5'd0, '0, 5'd9);
    finish_test("reset values and read/write", base);

    base = errors;
    send_csr(CSRRS, ADDR_MSCRATCH, 5'd2, 32'h0000_F0F0, 5'd1);
    send_csr(CSRRC, ADDR_MSCRATCH, 5'd3, 32'h0000_00F5, 5'd2);
    send_csr(CSRRSI, ADDR_MTVEC, 5'd31, '0, 5'd3);
    send_csr(CSRRCI, ADDR_MTVEC, 5'd5, '0, 5'd4);
    send_csr(CSRRS, ADDR_MSCRATCH, 5'd0, 32'hFFFF_FFFF, 5'd5);
    send_csr(CSRRC, ADDR_MTVEC, 5'd0, 32'hFFFF_FFFF, 5'd6);
    send_csr(CSRRCI, ADDR_MSCRATCH, 5'd0, '0, 5'd7);
    send_csr(CSRRS, ADDR_MTVEC, 5'd0, '0, 5'd8);
    finish_test("set and clear", base);

    base = errors;
    send_csr(CSRRW, ADDR_MCUSTOM, 5'd1, 32'hFFFF_FFEA, 5'd1);
    send_csr(CSRRSI, ADDR_MCUSTOM, 5'd31, '0, 5'd2);
    send_csr(CSRRC, ADDR_MCUSTOM, 5'd4, 32'hFFFF_FFF0, 5'd3);
    send_csr(CSRRS, ADDR_MCUSTOM, 5'd0, '0, 5'd4);
    finish_test("mcustom width", base);

    base = errors;
    send_csr(CSRRW, ADDR_MVENDORID, 5'd1, 32'h1234_5678, 5'd1);
    send_csr(CSRRSI, ADDR_MCYCLE, 5'd4, '0, 5'd2);
    send_csr(CSRRC, ADDR_MVENDORID, 5'd6, 32'hFFFF_FFFF, 5'd3);
    send_csr(CSRRS, 12'h123, 5'd0, '0, 5'd4);
    send_csr(CSRRWI, 12'h7C1, 5'd3, '0, 5'd5);
    send_csr(CSRRS, ADDR_MVENDORID, 5'd0, '0, 5'd6);
    send_csr(CSRRCI, ADDR_MCYCLE, 5'd0, '0, 5'd7);
    finish_test("illegal accesses", base);

    // model value is absolute, so k apart means a difference of k
    base = errors;
    for (k = 1; k <= 4; k++) begin
      send_csr(CSRRS, ADDR_MCYCLE, 5'd0, '0, 5'd10);
      repeat (k - 1) @(negedge clk);
      send_csr(CSRRS, ADDR_MCYCLE, 5'd0, '0, 5'd11);
    end
    finish_test("mcycle spacing", base);

    base = errors;
    for (k = 0; k < 80; k++) begin
      r = lcg_next();
      w = lcg_next();
      if (r[31:29] == 3'd0) begin
        // OP-IMM word, or SYSTEM with funct3 0 or 4
        if (r[28]) begin
          drive_word({w[31:7], 7'h13});
        end else begin
          drive_word({w[31:15], r[27], 2'b00, w[11:7], OPCODE_SYSTEM});
        end
      end else begin
        d  = lcg_next();
        f3 = (r[17:16] == 2'b00) ? (r[18:16] | 3'b001) : r[18:16];
        case (r[22:20])
          3'd0, 3'd5: addr = ADDR_MSCRATCH;
          3'd1:       addr = ADDR_MTVEC;
          3'd2, 3'd6: addr = ADDR_MCUSTOM;
          3'd3:       addr = ADDR_MCYCLE;
          3'd4:       addr = ADDR_MVENDORID;
          default:    addr = 12'h300;
        endcase
        send_csr(f3, addr, r[15:11], w, (d[31:30] == 2'b00) ? 5'd0 : d[29:25]);
      end
      if (r[9]) begin
        repeat (1 + r[8]) @(negedge clk);
      end
    end
    finish_test("random stream", base);

    $display("tests %0d, checks %0d, errors %0d, timeouts %0d", tests, checks, errors, timeouts);
    if (errors == 0 && timeouts == 0 && checks > 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

/* verilog.f */
verilog/csr_pkg.sv
verilog/csr_reg.sv
verilog/csr_decode.sv
verilog/csr_file.sv
verilog/csr_writeback.sv
verilog/csr_unit.sv
verification/csr_unit_checker.sv
verification/csr_unit_tb.sv

/* Makefile */
# Verilator flow for the CSR unit testbench
TOP = csr_unit_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f verilog.f -Mdir obj_dir -o $(TOP)

# the run fails unless the pass line appears in the output
run: compile
	@out="$$(./obj_dir/$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Result: PASSED"

clean:
	rm -rf obj_dir
